// File: hw/lsu_pkg.sv
package lsu_pkg;

    // Data path widths
    parameter int xlen       = 32;
    parameter int reg_addr_w = 5;
    parameter int byte_w     = 8;

    typedef enum logic [3:0] {
        NONE,
        ALU,
        LB,
        LBU,
        LH,
        LHU,
        LW,
        SB,
        SH,
        SW
    } lsu_op_e;

    typedef enum logic [1:0] {
        IDLE,
        XFER,
        FINISH
    } seq_state_e;

    // Byte transfers needed by an access, 0 for non-memory ops
    function automatic logic [2:0] bytes_of(lsu_op_e op);
        case (op)
            LB, LBU, SB: bytes_of = 3'd1;
            LH, LHU, SH: bytes_of = 3'd2;
            LW, SW:      bytes_of = 3'd4;
            default:     bytes_of = 3'd0;
        endcase
    endfunction

    function automatic logic is_load(lsu_op_e op);
        is_load = (op == LB) || (op == LBU) || (op == LH) || (op == LHU) || (op == LW);
    endfunction

    function automatic logic is_store(lsu_op_e op);
        is_store = (op == SB) || (op == SH) || (op == SW);
    endfunction

endpackage

// File: hw/lsu_sequencer.sv
`timescale 1ns/100ps

module lsu_sequencer import lsu_pkg::*; #(
    parameter int ADDR_W = 32
) (
    input  logic              clk,
    input  logic              arst_n_i,

    input  lsu_op_e           op_i,
    input  logic [ADDR_W-1:0] addr_i,
    input  logic [xlen-1:0]   wdata_i,
    input  logic              wb_ack_i,

    output logic              stall_o,
    output logic              done_o,

    // Toward the load merge
    output logic              cap_o,
    output logic [1:0]        idx_o,
    output logic              last_o,

    // Wishbone classic master
    output logic              wb_cyc_o,
    output logic              wb_stb_o,
    output logic              wb_we_o,
    output logic [ADDR_W-1:0] wb_adr_o,
    output logic [byte_w-1:0] wb_dat_o
);

    seq_state_e state_q;
    seq_state_e state_d;
    logic [1:0] idx_q;
    logic [1:0] idx_d;
    logic [2:0] n_bytes;
    logic       is_mem;
    logic       in_xfer;
    logic       final_byte;

    assign n_bytes = bytes_of(op_i);
    assign is_mem  = (n_bytes != 3'd0);
    assign in_xfer = (state_q == XFER);

    // Index of the last byte is the count minus one
    assign final_byte = ({1'b0, idx_q} == (n_bytes - 3'd1));

    ////////////////////
    // State machine
    ////////////////////

    always_comb begin
        state_d = state_q;
        idx_d   = idx_q;
        case (state_q)
            IDLE, FINISH: begin
                // A new access may be presented in the result cycle
                idx_d   = 2'd0;
                state_d = is_mem ? XFER : IDLE;
            end
            XFER: begin
                if (wb_ack_i) begin
                    if (final_byte) begin
                        state_d = FINISH;
                        idx_d   = 2'd0;
                    end else begin
                        idx_d = idx_q + 2'd1;
                    end
                end
            end
            default: begin
                state_d = IDLE;
                idx_d   = 2'd0;
            end
        endcase
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= IDLE;
            idx_q   <= 2'd0;
        end else begin
            state_q <= state_d;
            idx_q   <= idx_d;
        end
    end

    ////////////////////
    // Outputs
    ////////////////////

    // Held through the final ack cycle
    assign stall_o = in_xfer || is_mem;

    assign last_o = in_xfer && final_byte;
    assign done_o = last_o && wb_ack_i;
    assign cap_o  = in_xfer && wb_ack_i && is_load(op_i);
    assign idx_o  = idx_q;

    assign wb_cyc_o = in_xfer;
    assign wb_stb_o = in_xfer;
    assign wb_we_o  = in_xfer && is_store(op_i);

    // Little endian, byte k at base plus k
    assign wb_adr_o = addr_i + ADDR_W'(idx_q);
    assign wb_dat_o = wdata_i[idx_q*byte_w +: byte_w];

    ////////////////////
    // Checks
    ////////////////////

    // Strobe, cycle and address hold until the ack
    stb_held_until_ack: assert property (
        @(posedge clk) disable iff (!arst_n_i)
        (wb_stb_o && !wb_ack_i) |=> (wb_cyc_o && wb_stb_o && $stable(wb_adr_o))
    );

    idx_in_range: assert property (
        @(posedge clk) disable iff (!arst_n_i)
        in_xfer |-> ({1'b0, idx_q} < n_bytes)
    );

    // Upstream must hold the access until its last ack
    op_held_in_stall: assert property (
        @(posedge clk) disable iff (!arst_n_i)
        (stall_o && !done_o) |=> $stable(op_i)
    );

endmodule

// File: hw/lsu_load_merge.sv
`timescale 1ns/100ps

module lsu_load_merge import lsu_pkg::*; (
    input  logic              clk,
    input  logic              arst_n_i,
    input  lsu_op_e           op_i,
    input  logic [byte_w-1:0] wb_dat_i,
    input  logic              cap_i,
    input  logic [1:0]        idx_i,
    input  logic              last_i,
    output logic [xlen-1:0]   word_o
);

    logic [xlen/byte_w-1:0][byte_w-1:0] hold_q;
    logic [xlen/byte_w-1:0][byte_w-1:0] merged;
    logic [xlen-1:0]                    ext;

    // Byte lanes collected so far
    always_ff @(posedge clk) begin
        if (cap_i) begin
            hold_q[idx_i] <= wb_dat_i;
        end
    end

    // Final byte is taken straight off the bus
    always_comb begin
        merged = hold_q;
        if (cap_i) begin
            merged[idx_i] = wb_dat_i;
        end
    end

    always_comb begin
        case (op_i)
            LB:      ext = {{(xlen-8){merged[0][7]}}, merged[0]};
            LBU:     ext = {{(xlen-8){1'b0}}, merged[0]};
            LH:      ext = {{(xlen-16){merged[1][7]}}, merged[1], merged[0]};
            LHU:     ext = {{(xlen-16){1'b0}}, merged[1], merged[0]};
            LW:      ext = merged;
            default: ext = '0;
        endcase
    end

    // Zero unless a load completes this cycle
    assign word_o = (cap_i && last_i) ? ext : '0;

    ////////////////////
    // Checks
    ////////////////////

    cap_only_on_load: assert property (
        @(posedge clk) disable iff (!arst_n_i)
        cap_i |-> is_load(op_i)
    );

endmodule

// File: hw/lsu_top.sv
`timescale 1ns/100ps

module lsu_top import lsu_pkg::*; #(
    parameter int ADDR_W = 32
) (
    input  logic                  clk,
    input  logic                  arst_n_i,

    // Pipeline side
    input  lsu_op_e               op_i,
    input  logic [ADDR_W-1:0]     addr_i,
    input  logic [xlen-1:0]       wdata_i,
    input  logic [reg_addr_w-1:0] rd_i,
    input  logic                  rd_we_i,
    output logic                  stall_o,

    // Writeback side
    output logic                  res_valid_o,
    output logic                  res_we_o,
    output logic [reg_addr_w-1:0] res_rd_o,
    output logic [xlen-1:0]       res_data_o,

    // Wishbone byte master
    output logic                  wb_cyc_o,
    output logic                  wb_stb_o,
    output logic                  wb_we_o,
    output logic [ADDR_W-1:0]     wb_adr_o,
    output logic [byte_w-1:0]     wb_dat_o,
    input  logic [byte_w-1:0]     wb_dat_i,
    input  logic                  wb_ack_i
);

    logic       done;
    logic       cap;
    logic [1:0] idx;
    logic       last;
    logic [xlen-1:0] load_word;

    lsu_sequencer #(
        .ADDR_W (ADDR_W)
    ) u_sequencer (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .op_i     (op_i),
        .addr_i   (addr_i),
        .wdata_i  (wdata_i),
        .wb_ack_i (wb_ack_i),
        .stall_o  (stall_o),
        .done_o   (done),
        .cap_o    (cap),
        .idx_o    (idx),
        .last_o   (last),
        .wb_cyc_o (wb_cyc_o),
        .wb_stb_o (wb_stb_o),
        .wb_we_o  (wb_we_o),
        .wb_adr_o (wb_adr_o),
        .wb_dat_o (wb_dat_o)
    );

    lsu_load_merge u_load_merge (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .op_i     (op_i),
        .wb_dat_i (wb_dat_i),
        .cap_i    (cap),
        .idx_i    (idx),
        .last_i   (last),
        .word_o   (load_word)
    );

    ////////////////////
    // Writeback register
    ////////////////////

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            res_valid_o <= 1'b0;
            res_we_o    <= 1'b0;
        end else begin
            res_valid_o <= done || (op_i == ALU);
            res_we_o    <= done ? is_load(op_i) : ((op_i == ALU) && rd_we_i);
        end
    end

    // Store results come out of the merge as zero
    always_ff @(posedge clk) begin
        if (done) begin
            res_data_o <= load_word;
            res_rd_o   <= rd_i;
        end else if (op_i == ALU) begin
            res_data_o <= xlen'(addr_i);
            res_rd_o   <= rd_i;
        end
    end

endmodule

// File: tests/wb_byte_mem.sv
`timescale 1ns/100ps

module wb_byte_mem #(
    parameter int ADDR_W = 32
) (
    input  logic              clk,
    input  logic              arst_n_i,
    input  logic              wb_cyc_i,
    input  logic              wb_stb_i,
    input  logic              wb_we_i,
    input  logic [ADDR_W-1:0] wb_adr_i,
    input  logic [7:0]        wb_dat_i,
    output logic [7:0]        wb_dat_o,
    output logic              wb_ack_o,

    // Backdoor write port for the testbench
    input  logic              poke_en_i,
    input  logic [7:0]        poke_adr_i,
    input  logic [7:0]        poke_dat_i
);

    logic [7:0]  mem [256];
    logic [15:0] lfsr_q;
    logic [15:0] lfsr_nxt;
    logic [1:0]  wait_q;
    logic        busy_q;
    logic [7:0]  adr;

    assign adr = wb_adr_i[7:0];

    // Galois LFSR, taps 16,14,13,11
    function automatic logic [15:0] lfsr_step(logic [15:0] s);
        lfsr_step = s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    assign lfsr_nxt = lfsr_step(lfsr_q);

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wb_ack_o <= 1'b0;
            wb_dat_o <= 8'h00;
            busy_q   <= 1'b0;
            wait_q   <= 2'd0;
            lfsr_q   <= 16'd29;
            for (int i = 0; i < 256; i++) begin
                mem[i] <= 8'(i * 7) ^ 8'hA5;
            end
        end else begin
            wb_ack_o <= 1'b0;
            if (poke_en_i) begin
                mem[poke_adr_i] <= poke_dat_i;
            end
            if (wb_cyc_i && wb_stb_i && !wb_ack_o) begin
                if (!busy_q) begin
                    // Two bits drawn, one LFSR step each
                    wait_q <= {lfsr_q[0], lfsr_nxt[0]};
                    lfsr_q <= lfsr_step(lfsr_nxt);
                    busy_q <= 1'b1;
                end else if (wait_q == 2'd0) begin
                    wb_ack_o <= 1'b1;
                    busy_q   <= 1'b0;
                    if (wb_we_i) begin
                        mem[adr] <= wb_dat_i;
                    end else begin
                        wb_dat_o <= mem[adr];
                    end
                end else begin
                    wait_q <= wait_q - 2'd1;
                end
            end
        end
    end

endmodule

// File: tests/tb_lsu.sv
`timescale 1ns/100ps

module tb_lsu import lsu_pkg::*;;

    localparam int ADDR_W = 16;
    localparam int TIMEOUT_CYCLES = 40 * 16;

    logic              clk;
    logic              arst_n_i;
    lsu_op_e           op_i;
    logic [ADDR_W-1:0] addr_i;
    logic [31:0]       wdata_i;
    logic [4:0]        rd_i;
    logic              rd_we_i;
    logic              stall_o;
    logic              res_valid_o;
    logic              res_we_o;
    logic [4:0]        res_rd_o;
    logic [31:0]       res_data_o;
    logic              wb_cyc_o;
    logic              wb_stb_o;
    logic              wb_we_o;
    logic [ADDR_W-1:0] wb_adr_o;
    logic [7:0]        wb_dat_o;
    logic [7:0]        wb_dat_i;
    logic              wb_ack_i;
    logic              poke_en;
    logic [7:0]        poke_adr;
    logic [7:0]        poke_dat;
    logic [15:0]       lfsr;
    int                cycles;
    logic [7:0]        before_mem [256];

    lsu_top #(.ADDR_W(ADDR_W)) DUT (.*);

    wb_byte_mem #(.ADDR_W(ADDR_W)) mem_u (
        .clk        (clk),
        .arst_n_i   (arst_n_i),
        .wb_cyc_i   (wb_cyc_o),
        .wb_stb_i   (wb_stb_o),
        .wb_we_i    (wb_we_o),
        .wb_adr_i   (wb_adr_o),
        .wb_dat_i   (wb_dat_o),
        .wb_dat_o   (wb_dat_i),
        .wb_ack_o   (wb_ack_i),
        .poke_en_i  (poke_en),
        .poke_adr_i (poke_adr),
        .poke_dat_i (poke_dat)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("SIMULATION FAILED");
            $fatal(1, "timeout");
        end
    end

    ////////////////////
    // Helpers
    ////////////////////

    task automatic fail_now(input string msg);
        $display("error at %0t ns: %s", $time, msg);
        $display("SIMULATION FAILED");
        $fatal(1, "check failed");
    endtask

    // Galois LFSR, one step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
        end
        return v;
    endfunction

    function automatic int count_bytes(input lsu_op_e op);
        case (op)
            LB, LBU, SB: return 1;
            LH, LHU, SH: return 2;
            LW, SW:      return 4;
            default:     return 0;
        endcase
    endfunction

    function automatic logic [31:0] load_expect(input lsu_op_e op, input logic [31:0] w);
        case (op)
            LB:      return {{24{w[7]}}, w[7:0]};
            LBU:     return {24'h0, w[7:0]};
            LH:      return {{16{w[15]}}, w[15:0]};
            LHU:     return {16'h0, w[15:0]};
            default: return w;
        endcase
    endfunction

    task automatic poke_word(input logic [7:0] addr, input logic [31:0] w);
        for (int k = 0; k < 4; k++) begin
            @(posedge clk);
            poke_en  <= 1'b1;
            poke_adr <= addr + 8'(k);
            poke_dat <= w[8*k +: 8];
        end
        @(posedge clk);
        poke_en <= 1'b0;
    endtask

    // One load or store, checking the bus and stall on every edge
    task automatic run_access(input lsu_op_e op, input logic [15:0] addr,
                              input logic [31:0] wdata, input logic [4:0] rd,
                              output logic [31:0] data, output logic we);
        int   n;
        int   acks;
        logic fin;
        n    = count_bytes(op);
        acks = 0;
        fin  = 1'b0;
        @(posedge clk);
        op_i    <= op;
        addr_i  <= addr;
        wdata_i <= wdata;
        rd_i    <= rd;
        rd_we_i <= 1'b0;
        while (!fin) begin
            @(posedge clk);
            assert (stall_o) else fail_now("stall_o low before the last ack");
            assert (!res_valid_o) else fail_now("res_valid_o before the last ack");
            if (wb_cyc_o && wb_ack_i) begin
                assert (wb_stb_o) else fail_now("wb_stb_o low at an ack");
                assert (wb_adr_o == addr + 16'(acks))
                    else fail_now($sformatf("byte %0d address %h", acks, wb_adr_o));
                assert (wb_we_o == (op inside {SB, SH, SW}))
                    else fail_now("wb_we_o does not match the operation");
                acks++;
                if (acks == n) begin
                    op_i <= NONE;
                    fin = 1'b1;
                end
            end
        end
        @(posedge clk);
        assert (res_valid_o) else fail_now("res_valid_o missing after last ack");
        assert (!stall_o) else fail_now("stall_o high in the result cycle");
        assert (!wb_cyc_o && !wb_ack_i) else fail_now("extra bus cycle after last ack");
        assert (res_rd_o == rd) else fail_now($sformatf("res_rd_o %0d", res_rd_o));
        data = res_data_o;
        we   = res_we_o;
        @(posedge clk);
        assert (!res_valid_o) else fail_now("res_valid_o longer than one cycle");
    endtask

    ////////////////////
    // Tests
    ////////////////////

    task automatic test_alu();
        logic [15:0] a;
        logic [4:0]  rd;
        logic        we;
        for (int i = 0; i < 4; i++) begin
            a  = 16'(rand_bits(16));
            rd = 5'(rand_bits(5));
            we = 1'(rand_bits(1));
            @(posedge clk);
            op_i    <= ALU;
            addr_i  <= a;
            rd_i    <= rd;
            rd_we_i <= we;
            @(posedge clk);
            assert (!stall_o) else fail_now("stall_o high on an ALU op");
            op_i <= NONE;
            @(posedge clk);
            assert (res_valid_o && res_data_o == {16'h0, a} && res_we_o == we
                    && res_rd_o == rd)
                else fail_now($sformatf("ALU result %h we %b", res_data_o, res_we_o));
        end
    endtask

    task automatic test_stores();
        lsu_op_e     ops [3];
        logic [7:0]  a;
        logic [31:0] w;
        logic [31:0] data;
        logic        we;
        logic [7:0]  exp;
        int          n;
        ops = '{SB, SH, SW};
        foreach (ops[j]) begin
            a = 8'(rand_bits(8) % 252);
            w = rand_bits(32);
            n = count_bytes(ops[j]);
            for (int i = 0; i < 256; i++) begin
                before_mem[i] = mem_u.mem[i];
            end
            run_access(ops[j], {8'h0, a}, w, 5'd3, data, we);
            assert (!we && data == 32'h0) else fail_now("store result not zero");
            for (int i = 0; i < 256; i++) begin
                exp = (i >= a && i < a + n) ? w[8*(i-a) +: 8] : before_mem[i];
                assert (mem_u.mem[i] == exp)
                    else fail_now($sformatf("mem[%0d] %h want %h", i, mem_u.mem[i], exp));
            end
        end
    endtask

    task automatic test_loads();
        lsu_op_e     ops [5];
        logic [31:0] pats [2];
        logic [31:0] data;
        logic        we;
        ops  = '{LB, LBU, LH, LHU, LW};
        pats = '{32'h913C_F285, 32'h6EA0_1742};
        foreach (pats[p]) begin
            poke_word(8'h40 + 8'(p * 8), pats[p]);
            foreach (ops[j]) begin
                run_access(ops[j], 16'h40 + 16'(p * 8), 32'h0, 5'd9, data, we);
                assert (we && data == load_expect(ops[j], pats[p]))
                    else fail_now($sformatf("load %s got %h", ops[j].name(), data));
            end
        end
    endtask

    task automatic test_round_trip();
        logic [15:0] a;
        logic [31:0] w;
        logic [31:0] data;
        logic        we;
        for (int i = 0; i < 3; i++) begin
            a = 16'(rand_bits(8) % 252);
            w = rand_bits(32);
            run_access(SW, a, w, 5'd1, data, we);
            run_access(LW, a, 32'h0, 5'd2, data, we);
            assert (data == w) else fail_now($sformatf("round trip %h want %h", data, w));
        end
    endtask

    initial begin
        clk      = 1'b0;
        arst_n_i = 1'b0;
        op_i     = NONE;
        addr_i   = '0;
        wdata_i  = '0;
        rd_i     = '0;
        rd_we_i  = 1'b0;
        poke_en  = 1'b0;
        poke_adr = '0;
        poke_dat = '0;
        lfsr     = 16'd29;
        cycles   = 0;
        repeat (3) @(posedge clk);
        assert (!stall_o && !res_valid_o && !wb_cyc_o && !wb_stb_o)
            else fail_now("outputs active during reset");
        arst_n_i <= 1'b1;
        @(posedge clk);
        assert (!stall_o && !res_valid_o && !wb_cyc_o && !wb_stb_o)
            else fail_now("outputs active at reset release");
        test_alu();
        test_stores();
        test_loads();
        test_round_trip();
        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

// File: tb.f
hw/lsu_pkg.sv
hw/lsu_sequencer.sv
hw/lsu_load_merge.sv
hw/lsu_top.sv
tests/wb_byte_mem.sv
tests/tb_lsu.sv

// File: run.sh
#!/bin/sh
# Compile and run the LSU testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module tb_lsu -f tb.f -o sim_lsu \
    && ./obj_dir/sim_lsu \
    || exit 1
